// ==== src/trace_cfg_pkg.sv ====
package trace_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Pipeline and stamp sizing
    //////////////////////////////////////////////////////////////////////
    localparam int num_stages  = 5;                     // IF ID EX MEM WB
    localparam int tag_w       = 8;
    localparam int slot_depth  = 16;                    // Entries per stamp table
    localparam int slot_aw     = $clog2(slot_depth);
    localparam int cycle_w     = 16;
    localparam int flush_cnt_w = 16;

    //////////////////////////////////////////////////////////////////////
    // Record buffer and bus map
    //////////////////////////////////////////////////////////////////////
    localparam int fifo_depth  = 4;
    localparam int fifo_aw     = $clog2(fifo_depth);
    localparam int count_w     = $clog2(fifo_depth + 1); // 0 to fifo_depth
    localparam int rec_words   = 5;                     // 32-bit words per record
    localparam int word_ptr_w  = $clog2(rec_words);
    localparam int data_w      = 32;
    localparam int adr_w       = 4;
    localparam int addr_status = 0;                     // Byte address
    localparam int addr_data   = 4;                     // Byte address

endpackage

// ==== src/trace_types_pkg.sv ====
package trace_types_pkg;

    import trace_cfg_pkg::*;

    typedef enum logic [2:0] {
        st_if  = 3'd0,
        st_id  = 3'd1,
        st_ex  = 3'd2,
        st_mem = 3'd3,
        st_wb  = 3'd4
    } stage_e;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } stage_tag_t;

    typedef stage_tag_t [num_stages-1:0] stage_tag_vec_t;           // Indexed by stage_e
    typedef logic [num_stages-1:0][cycle_w-1:0] stamp_vec_t;        // Indexed by stage_e

    typedef struct packed {
        logic [data_w-1:0] pc;
        logic [data_w-1:0] instr;
    } fetch_info_t;

    // 152 bits, read out as five bus words
    typedef struct packed {
        logic [data_w-1:0] pc;
        logic [data_w-1:0] instr;
        logic [tag_w-1:0]  tag;
        stamp_vec_t        stamp;
    } trace_rec_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [adr_w-1:0]  adr;
        logic [data_w-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [data_w-1:0] dat;
    } wb_rsp_t;

    typedef enum logic {
        ps_idle,
        ps_ack
    } port_state_e;

endpackage

// ==== src/trace_tagger.sv ====
module trace_tagger (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [trace_cfg_pkg::num_stages-1:0]  stage_valid,
    input  logic                                  stall,
    input  logic                                  flush,
    output trace_types_pkg::stage_tag_vec_t       stage_tags,
    output logic [trace_cfg_pkg::cycle_w-1:0]     cycle,
    output logic [trace_cfg_pkg::flush_cnt_w-1:0] flush_count
);

    import trace_cfg_pkg::*;
    import trace_types_pkg::*;

    logic [tag_w-1:0] next_tag;      // Fetches that have left IF
    logic [tag_w-1:0] next_tag_nxt;
    logic             if_hold;
    logic             if_leave;
    logic [1:0]       killed;
    stage_tag_vec_t   tags_nxt;

    assign if_hold      = stall && !flush && stage_valid[st_if]; // Stall keeps IF
    assign if_leave     = stage_valid[st_if] && !if_hold;         // Advances or dies
    assign next_tag_nxt = next_tag + tag_w'(if_leave);
    assign killed       = flush ? 2'(stage_valid[st_if]) + 2'(stage_valid[st_id]) : 2'd0;

    //////////////////////////////////////////////////////////////////////
    // Tag movement, same rules as the processor
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        tags_nxt[st_wb]  = {stage_valid[st_mem], stage_tags[st_mem].tag};
        tags_nxt[st_mem] = {stage_valid[st_ex], stage_tags[st_ex].tag};

        if (stall || flush) begin
            tags_nxt[st_ex] = '0;                                 // Bubble
        end else begin
            tags_nxt[st_ex] = {stage_valid[st_id], stage_tags[st_id].tag};
        end

        if (flush) begin
            tags_nxt[st_id] = '0;
        end else if (stall) begin
            tags_nxt[st_id] = {stage_valid[st_id], stage_tags[st_id].tag};
        end else begin
            tags_nxt[st_id] = {stage_valid[st_if], stage_tags[st_if].tag};
        end

        // A free IF slot carries the tag the next fetch will get
        if (flush) begin
            tags_nxt[st_if] = '0;
        end else if (if_hold) begin
            tags_nxt[st_if] = stage_tags[st_if];
        end else begin
            tags_nxt[st_if] = {1'b1, next_tag_nxt};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle       <= '0;
            next_tag    <= '0;
            stage_tags  <= '0;
            flush_count <= '0;
        end else begin
            cycle       <= cycle + 1'b1;
            next_tag    <= next_tag_nxt;
            stage_tags  <= tags_nxt;
            flush_count <= flush_count + flush_cnt_w'(killed);
        end
    end

    // Every occupied stage has a tag from the shift register
    for (genvar k = 0; k < num_stages; k++) begin : g_chk
        a_tag_valid: assert property (@(posedge clk) disable iff (rst)
            stage_valid[k] |-> stage_tags[k].valid);
    end

endmodule

// ==== src/stage_stamp_slot.sv ====
module stage_stamp_slot (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              present,
    input  trace_types_pkg::stage_tag_t       stage_tag,
    input  logic [trace_cfg_pkg::cycle_w-1:0] cycle,
    input  logic [trace_cfg_pkg::tag_w-1:0]   rd_tag,
    output logic [trace_cfg_pkg::cycle_w-1:0] rd_cycle
);

    import trace_cfg_pkg::*;

    logic [cycle_w-1:0] stamp_mem [slot_depth];
    logic [tag_w-1:0]   prev_tag;
    logic               prev_present;
    logic               first;       // First cycle of this tag in the stage

    assign first = present && (!prev_present || stage_tag.tag != prev_tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_present <= 1'b0;
        end else begin
            prev_present <= present;
        end
    end

    always_ff @(posedge clk) begin
        prev_tag <= stage_tag.tag;
        if (first) begin
            stamp_mem[stage_tag.tag[slot_aw-1:0]] <= cycle;
        end
    end

    // Bypass lets WB be read during its only cycle
    assign rd_cycle = (first && rd_tag == stage_tag.tag) ? cycle
                                                         : stamp_mem[rd_tag[slot_aw-1:0]];

    a_rise_valid: assert property (@(posedge clk) disable iff (rst)
        $rose(present) |-> stage_tag.valid);

endmodule

// ==== src/trace_record_writer.sv ====
module trace_record_writer (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [trace_cfg_pkg::num_stages-1:0] stage_valid,
    input  trace_types_pkg::fetch_info_t         fetch,
    input  trace_types_pkg::stage_tag_vec_t      stage_tags,
    output logic [trace_cfg_pkg::tag_w-1:0]      rd_tag,
    input  trace_types_pkg::stamp_vec_t          rd_cycles,
    input  logic                                 pop,
    output logic                                 rec_valid,
    output trace_types_pkg::trace_rec_t          rec_head,
    output logic [trace_cfg_pkg::count_w-1:0]    rec_count,
    output logic                                 overflow
);

    import trace_cfg_pkg::*;
    import trace_types_pkg::*;

    fetch_info_t        fetch_mem [slot_depth];   // pc and instr by tag
    trace_rec_t         fifo_mem  [fifo_depth];
    fetch_info_t        wb_fetch;
    trace_rec_t         new_rec;
    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    logic [count_w-1:0] count;
    logic               push;
    logic               full;
    logic               push_ok;
    logic               pop_ok;

    //////////////////////////////////////////////////////////////////////
    // Record assembly at writeback
    //////////////////////////////////////////////////////////////////////
    assign rd_tag   = stage_tags[st_wb].tag;
    assign wb_fetch = fetch_mem[rd_tag[slot_aw-1:0]];

    always_comb begin
        new_rec.pc    = wb_fetch.pc;
        new_rec.instr = wb_fetch.instr;
        new_rec.tag   = rd_tag;
        new_rec.stamp = rd_cycles;
    end

    always_ff @(posedge clk) begin
        if (stage_valid[st_if]) begin
            fetch_mem[stage_tags[st_if].tag[slot_aw-1:0]] <= fetch;
        end
        if (push_ok) begin
            fifo_mem[wr_ptr] <= new_rec;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Record FIFO
    //////////////////////////////////////////////////////////////////////
    assign push    = stage_valid[st_wb];
    assign full    = count == count_w'(fifo_depth);
    assign push_ok = push && !full;                  // Dropped when full
    assign pop_ok  = pop && rec_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + count_w'(push_ok) - count_w'(pop_ok);
            if (push && full) begin
                overflow <= 1'b1;                    // Sticky
            end
        end
    end

    assign rec_valid = count != '0;
    assign rec_head  = fifo_mem[rd_ptr];
    assign rec_count = count;

    a_pop_nonempty: assert property (@(posedge clk) disable iff (rst)
        pop |-> rec_valid);

    // WB follows MEM by exactly one cycle, so its stamp is the current cycle
    a_wb_stamp: assert property (@(posedge clk) disable iff (rst)
        stage_valid[st_wb] |-> rd_cycles[st_wb] == cycle_w'(rd_cycles[st_mem] + 1'b1));

endmodule

// ==== src/trace_wb_port.sv ====
module trace_wb_port (
    input  logic                                  clk,
    input  logic                                  rst,
    input  trace_types_pkg::wb_req_t              wb_req,
    output trace_types_pkg::wb_rsp_t              wb_rsp,
    input  logic                                  rec_valid,
    input  trace_types_pkg::trace_rec_t           rec_head,
    input  logic [trace_cfg_pkg::count_w-1:0]     rec_count,
    input  logic                                  overflow,
    input  logic [trace_cfg_pkg::flush_cnt_w-1:0] flush_count,
    output logic                                  pop
);

    import trace_cfg_pkg::*;
    import trace_types_pkg::*;

    port_state_e           state;
    logic [word_ptr_w-1:0] word_ptr;     // Next word of the head record
    logic [data_w-1:0]     rsp_dat;
    logic [data_w-1:0]     rec_word;
    logic [data_w-1:0]     status_word;
    logic [data_w-1:0]     rd_word;
    logic                  req_new;
    logic                  data_rd;
    logic                  advance;
    logic                  last_word;
    logic                  pop_q;

    assign req_new   = state == ps_idle && wb_req.cyc && wb_req.stb;
    assign data_rd   = !wb_req.we && wb_req.adr == adr_w'(addr_data);
    assign advance   = data_rd && rec_valid;  // Empty reads move nothing
    assign last_word = word_ptr == word_ptr_w'(rec_words - 1);

    //////////////////////////////////////////////////////////////////////
    // Read data selection
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (word_ptr)
            word_ptr_w'(0): rec_word = rec_head.pc;
            word_ptr_w'(1): rec_word = rec_head.instr;
            word_ptr_w'(2): rec_word = {rec_head.tag, {(data_w - tag_w - cycle_w){1'b0}},
                                        rec_head.stamp[st_if]};
            word_ptr_w'(3): rec_word = {rec_head.stamp[st_id], rec_head.stamp[st_ex]};
            default:        rec_word = {rec_head.stamp[st_mem], rec_head.stamp[st_wb]};
        endcase
    end

    assign status_word = {flush_count, 7'd0, overflow, 5'd0, rec_count};
    assign rd_word     = data_rd ? (rec_valid ? rec_word : '0) : status_word;

    //////////////////////////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ps_idle;
            word_ptr <= '0;
            pop_q    <= 1'b0;
        end else begin
            case (state)
                ps_idle: begin
                    if (req_new) begin
                        state <= ps_ack;
                        pop_q <= advance && last_word;
                        if (advance) begin
                            word_ptr <= last_word ? '0 : word_ptr + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ps_idle;                    // One ack, then idle
                    pop_q <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_new) begin
            rsp_dat <= rd_word;
        end
    end

    always_comb begin
        wb_rsp.ack = state == ps_ack;
        wb_rsp.dat = rsp_dat;
    end

    assign pop = state == ps_ack && pop_q;      // With the fifth data ack

    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack);

endmodule

// ==== src/pipeline_trace_top.sv ====
module pipeline_trace_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [trace_cfg_pkg::num_stages-1:0] stage_valid,
    input  trace_types_pkg::fetch_info_t         fetch,
    input  logic                                 stall,
    input  logic                                 flush,
    input  trace_types_pkg::wb_req_t             wb_req,
    output trace_types_pkg::wb_rsp_t             wb_rsp
);

    import trace_cfg_pkg::*;
    import trace_types_pkg::*;

    stage_tag_vec_t         stage_tags;
    logic [cycle_w-1:0]     cycle;
    logic [flush_cnt_w-1:0] flush_count;
    logic [tag_w-1:0]       rd_tag;       // Current WB tag
    stamp_vec_t             rd_cycles;
    logic                   pop;
    logic                   rec_valid;
    trace_rec_t             rec_head;
    logic [count_w-1:0]     rec_count;
    logic                   overflow;

    trace_tagger u_tagger (
        .clk         (clk),
        .rst         (rst),
        .stage_valid (stage_valid),
        .stall       (stall),
        .flush       (flush),
        .stage_tags  (stage_tags),
        .cycle       (cycle),
        .flush_count (flush_count)
    );

    // One stamp table per stage
    for (genvar k = int'(st_if); k <= int'(st_wb); k++) begin : g_slot
        stage_stamp_slot u_slot (
            .clk       (clk),
            .rst       (rst),
            .present   (stage_valid[k]),
            .stage_tag (stage_tags[k]),
            .cycle     (cycle),
            .rd_tag    (rd_tag),
            .rd_cycle  (rd_cycles[k])
        );
    end

    trace_record_writer u_writer (
        .clk         (clk),
        .rst         (rst),
        .stage_valid (stage_valid),
        .fetch       (fetch),
        .stage_tags  (stage_tags),
        .rd_tag      (rd_tag),
        .rd_cycles   (rd_cycles),
        .pop         (pop),
        .rec_valid   (rec_valid),
        .rec_head    (rec_head),
        .rec_count   (rec_count),
        .overflow    (overflow)
    );

    trace_wb_port u_wb_port (
        .clk         (clk),
        .rst         (rst),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .rec_valid   (rec_valid),
        .rec_head    (rec_head),
        .rec_count   (rec_count),
        .overflow    (overflow),
        .flush_count (flush_count),
        .pop         (pop)
    );

endmodule

// ==== testbench/tb_wb_master.sv ====
module tb_wb_master (
    input  logic                     clk,
    output trace_types_pkg::wb_req_t wb_req,
    input  trace_types_pkg::wb_rsp_t wb_rsp
);

    timeunit 1ns;
    timeprecision 100ps;

    import trace_cfg_pkg::*;
    import trace_types_pkg::*;

    initial begin
        wb_req = '0;                              // Bus idle from time zero
    end

    //////////////////////////////////////////////////////////////////////
    // Classic read, called a short delay after a rising edge
    //////////////////////////////////////////////////////////////////////
    task automatic read(input logic [adr_w-1:0] adr, output logic [data_w-1:0] dat,
                        output bit ok);
        int waited;
        ok         = 1'b0;
        dat        = '0;
        waited     = 0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;                         // Held until ack
        wb_req.dat = '0;
        while (!ok && waited < 20) begin
            @(posedge clk);
            #2;
            waited++;
            if (wb_rsp.ack) begin
                ok  = 1'b1;
                dat = wb_rsp.dat;
            end
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
    endtask

endmodule

// ==== testbench/tb_pipeline_trace.sv ====
module tb_pipeline_trace;

    timeunit 1ns;
    timeprecision 100ps;

    import trace_cfg_pkg::*;
    import trace_types_pkg::*;

    typedef struct packed {
        logic               valid;
        logic [cycle_w-1:0] id_wait;                 // Stall cycles held in ID
        trace_rec_t         rec;
    } stage_ent_t;

    typedef stage_ent_t [num_stages-1:0] pipe_t;     // Indexed by stage_e

    logic                  clk;
    logic                  rst;
    logic [num_stages-1:0] stage_valid;
    fetch_info_t           fetch;
    logic                  stall;
    logic                  flush;
    wb_req_t               wb_req;
    wb_rsp_t               wb_rsp;

    integer             seed = 68;
    logic [cycle_w-1:0] tb_cycle;                     // Expected DUT cycle count
    pipe_t              pipe;
    trace_rec_t         exp_q [$];
    int                 exp_gap_q [$];                // ID to EX gap per record
    int                 exp_flushes;
    int                 fetch_total;
    int                 errors;
    int                 test_start_errors;
    int                 tests_passed;
    int                 tests_failed;

    pipeline_trace_top UUT (
        .clk         (clk),
        .rst         (rst),
        .stage_valid (stage_valid),
        .fetch       (fetch),
        .stall       (stall),
        .flush       (flush),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp)
    );

    tb_wb_master u_master (
        .clk    (clk),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            tb_cycle <= '0;
        end else begin
            tb_cycle <= tb_cycle + 1'b1;
        end
    end

    initial begin
        repeat (20000) @(posedge clk);
        $display("error: the run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Checks and helpers
    //////////////////////////////////////////////////////////////////////
    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic bit chance(input int pct);
        return (($random(seed) & 32'h7fff_ffff) % 100) < pct;
    endfunction

    // Any stage of the model still holding an instruction
    function automatic bit pipe_busy();
        bit busy;
        busy = 1'b0;
        for (int k = 0; k < num_stages; k++) begin
            busy |= pipe[k].valid;
        end
        return busy;
    endfunction

    task automatic bus_read(input int adr, output logic [data_w-1:0] dat);
        bit ok;
        u_master.read(adr_w'(adr), dat, ok);
        if (!ok) begin
            errors++;
            $display("error: bus read at address %0d got no ack", adr);
        end
    endtask

    // One clock of the processor model
    task automatic step(input bit want_fetch, input bit do_stall, input bit do_flush,
                        output bit took);
        pipe_t              nxt;
        logic [cycle_w-1:0] c1;
        bit                 hold;
        for (int k = 0; k < num_stages; k++) begin
            stage_valid[k] = pipe[k].valid;
        end
        fetch.pc    = pipe[st_if].rec.pc;
        fetch.instr = pipe[st_if].rec.instr;
        stall       = do_stall;
        flush       = do_flush;
        if (pipe[st_wb].valid) begin
            exp_q.push_back(pipe[st_wb].rec);          // Retires this cycle
            exp_gap_q.push_back(1 + int'(pipe[st_wb].id_wait));
        end
        if (do_flush) begin
            exp_flushes += int'(pipe[st_if].valid) + int'(pipe[st_id].valid);
        end
        c1   = tb_cycle + 1'b1;
        hold = do_stall && !do_flush && pipe[st_if].valid;
        took = 1'b0;
        nxt[st_wb]                     = pipe[st_mem];
        nxt[st_wb].rec.stamp[st_wb]    = c1;
        nxt[st_mem]                    = pipe[st_ex];
        nxt[st_mem].rec.stamp[st_mem]  = c1;
        if (do_stall || do_flush) begin
            nxt[st_ex] = '0;                           // Bubble
        end else begin
            nxt[st_ex]                 = pipe[st_id];
            nxt[st_ex].rec.stamp[st_ex] = c1;
        end
        if (do_flush) begin
            nxt[st_id] = '0;
        end else if (do_stall) begin
            nxt[st_id]         = pipe[st_id];
            nxt[st_id].id_wait = pipe[st_id].id_wait + 1'b1;
        end else begin
            nxt[st_id]                 = pipe[st_if];
            nxt[st_id].rec.stamp[st_id] = c1;
        end
        if (do_flush) begin
            nxt[st_if] = '0;
        end else if (hold) begin
            nxt[st_if] = pipe[st_if];
        end else if (want_fetch) begin
            nxt[st_if]                 = '0;
            nxt[st_if].valid           = 1'b1;
            nxt[st_if].rec.tag         = tag_w'(fetch_total);
            nxt[st_if].rec.pc          = $random(seed);
            nxt[st_if].rec.instr       = $random(seed);
            nxt[st_if].rec.stamp[st_if] = c1;
            fetch_total++;
            took = 1'b1;
        end else begin
            nxt[st_if] = '0;
        end
        @(posedge clk);
        #2;
        pipe = nxt;
    endtask

    task automatic run_burst(input int n_fetch, input int stall_pct, input int flush_pct);
        int taken;
        int guard;
        bit took;
        taken = 0;
        guard = 0;
        while (taken < n_fetch && guard < 60) begin
            step(chance(75), chance(stall_pct), chance(flush_pct), took);
            taken += int'(took);
            guard++;
        end
        if (taken < n_fetch) begin
            errors++;
            $display("error: burst issued only %0d of %0d fetches", taken, n_fetch);
        end
        guard = 0;
        while (pipe_busy() && guard < 20) begin
            step(1'b0, 1'b0, 1'b0, took);
            guard++;
        end
        if (pipe_busy()) begin
            errors++;
            $display("error: pipeline model did not drain");
        end
        step(1'b0, 1'b0, 1'b0, took);                // Leaves inputs idle
    endtask

    task automatic check_status(input int exp_count, input bit exp_ovf);
        logic [data_w-1:0] s;
        bus_read(addr_status, s);
        check_value("status rec_count", 64'(s[2:0]), 64'(exp_count));
        check_value("status overflow", 64'(s[8]), 64'(exp_ovf));
        check_value("status flush_count", 64'(s[31:16]), 64'(exp_flushes));
    endtask

    task automatic read_record(output trace_rec_t r);
        logic [data_w-1:0] w [rec_words];
        for (int i = 0; i < rec_words; i++) begin
            bus_read(addr_data, w[i]);
        end
        r.pc            = w[0];
        r.instr         = w[1];
        r.tag           = w[2][31:24];
        r.stamp[st_if]  = w[2][15:0];
        r.stamp[st_id]  = w[3][31:16];
        r.stamp[st_ex]  = w[3][15:0];
        r.stamp[st_mem] = w[4][31:16];
        r.stamp[st_wb]  = w[4][15:0];
    endtask

    task automatic read_and_check(input int n, input bit check_rise, input bit check_gap);
        trace_rec_t got;
        trace_rec_t exp;
        int         exp_gap;
        for (int i = 0; i < n; i++) begin
            read_record(got);
            if (exp_q.size() == 0) begin
                errors++;
                $display("error: a record was read with none expected");
            end else begin
                exp     = exp_q.pop_front();
                exp_gap = exp_gap_q.pop_front();
                check_value("record tag", 64'(got.tag), 64'(exp.tag));
                check_value("record pc", 64'(got.pc), 64'(exp.pc));
                check_value("record instr", 64'(got.instr), 64'(exp.instr));
                for (int k = 0; k < num_stages; k++) begin
                    check_value($sformatf("stamp of stage %0d", k),
                                64'(got.stamp[k]), 64'(exp.stamp[k]));
                end
                if (check_rise) begin
                    for (int k = 1; k < num_stages; k++) begin
                        check_value("stamp step", 64'(cycle_w'(got.stamp[k] - got.stamp[k-1])),
                                    64'd1);
                    end
                end
                if (check_gap) begin
                    check_value("ID to EX gap",
                                64'(cycle_w'(got.stamp[st_ex] - got.stamp[st_id])),
                                64'(exp_gap));
                end
            end
        end
    endtask

    task automatic drain_check(input bit check_rise, input bit check_gap);
        int n;
        n = exp_q.size();
        check_status(n, 1'b0);
        read_and_check(n, check_rise, check_gap);
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [data_w-1:0] d;
        bit                took;
        rst               = 1'b1;
        stage_valid       = '0;
        fetch             = '0;
        stall             = 1'b0;
        flush             = 1'b0;
        pipe              = '0;
        exp_flushes       = 0;
        fetch_total       = 0;
        errors            = 0;
        test_start_errors = 0;
        tests_passed      = 0;
        tests_failed      = 0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        step(1'b0, 1'b0, 1'b0, took);
        step(1'b0, 1'b0, 1'b0, took);

        check_status(0, 1'b0);                        // Reset state
        bus_read(addr_data, d);
        check_value("empty data read", 64'(d), 64'd0);
        check_status(0, 1'b0);
        end_test("1 reset state");

        repeat (4) begin
            run_burst(3, 0, 0);
            drain_check(1'b1, 1'b0);
        end
        end_test("2 plain flow");

        repeat (5) begin
            run_burst(3, 30, 0);
            drain_check(1'b0, 1'b1);
        end
        end_test("3 random stalls");

        repeat (5) begin
            run_burst(3, 20, 20);
            drain_check(1'b0, 1'b0);
        end
        check_status(0, 1'b0);
        end_test("4 random flushes");

        run_burst(6, 0, 0);                           // No reads, FIFO fills
        check_status(4, 1'b1);
        read_and_check(4, 1'b0, 1'b0);
        exp_q.delete();
        exp_gap_q.delete();
        check_status(0, 1'b1);
        end_test("5 overflow");

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/trace_cfg_pkg.sv
src/trace_types_pkg.sv
src/trace_tagger.sv
src/stage_stamp_slot.sv
src/trace_record_writer.sv
src/trace_wb_port.sv
src/pipeline_trace_top.sv
testbench/tb_wb_master.sv
testbench/tb_pipeline_trace.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pipeline_trace
RTL_TOP   ?= pipeline_trace_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
